// File: src/spi_host_consts.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI host constants
// Frame width, serial clock divider and queue depth for the host subsystem
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef SPI_HOST_CONSTS_SVH
`define SPI_HOST_CONSTS_SVH

// Bits shifted per chip select frame
`define SPI_DATA_WIDTH 16

// System clocks per half period of the serial clock
`define SPI_CLK_DIV 4

// Entries in each of the command and response queues
`define SPI_FIFO_DEPTH 4

`endif

// File: src/spi_host_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI host package
// Payload types carried on the command and response streams
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "spi_host_consts.svh"

package spi_host_pkg;

    // Host to device word, sent MSB first
    typedef struct packed {
        logic [`SPI_DATA_WIDTH-1:0] data;   // Transmit word
    } spi_cmd_t;

    // Device to host word, in arrival order
    typedef struct packed {
        logic [`SPI_DATA_WIDTH-1:0] data;   // Received word
    } spi_rsp_t;

endpackage

// File: src/spi_xfer_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Transfer FIFO
// Synchronous valid/ready queue taking one write and one read per cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "spi_host_consts.svh"

module spi_xfer_fifo #(
    parameter type payload_t = logic [`SPI_DATA_WIDTH-1:0],
    parameter int  DEPTH     = `SPI_FIFO_DEPTH
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;       // Occupied entries
    logic [AW:0]   count_nxt;
    logic          wr_en;
    logic          rd_en;

    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
        if (p == AW'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign wr_en     = in_valid && in_ready;
    assign rd_en     = out_valid && out_ready;
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];    // Head entry

    always_comb begin
        count_nxt = count;
        if (wr_en && !rd_en) begin
            count_nxt = count + 1'b1;
        end else if (rd_en && !wr_en) begin
            count_nxt = count - 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            in_ready <= 1'b0;           // Low until reset is released
        end else begin
            if (wr_en) wr_ptr <= ptr_inc(wr_ptr);
            if (rd_en) rd_ptr <= ptr_inc(rd_ptr);
            count    <= count_nxt;
            in_ready <= (count_nxt != (AW+1)'(DEPTH));
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_ptr] <= in_data;
    end

endmodule

// File: src/spi_sclk_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI serial clock generator
// Divides the system clock and flags the rising and falling serial edges
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "spi_host_consts.svh"

module spi_sclk_gen (
    input  logic clk,
    input  logic rst,
    input  logic enable,
    output logic sclk,
    output logic launch,
    output logic sample
);

    localparam int DIV = `SPI_CLK_DIV;
    localparam int CW  = (DIV > 1) ? $clog2(DIV) : 1;

    logic [CW-1:0] div_cnt;
    logic          half_done;

    assign half_done = (div_cnt == CW'(DIV - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            sclk    <= 1'b0;
            launch  <= 1'b0;
            sample  <= 1'b0;
        end else if (!enable) begin
            // Park in mode 0 idle level
            div_cnt <= '0;
            sclk    <= 1'b0;
            launch  <= 1'b0;
            sample  <= 1'b0;
        end else if (half_done) begin
            div_cnt <= '0;
            sclk    <= ~sclk;
            sample  <= ~sclk;           // Rising serial edge
            launch  <= sclk;            // Falling serial edge
        end else begin
            div_cnt <= div_cnt + 1'b1;
            launch  <= 1'b0;
            sample  <= 1'b0;
        end
    end

endmodule

// File: src/spi_shift_reg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI shift register
// Full-duplex MSB-first shifter between the host word and the data pins
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "spi_host_consts.svh"

module spi_shift_reg (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  load,
    input  spi_host_pkg::spi_cmd_t load_data,
    input  logic                  launch,
    input  logic                  sample,
    input  logic                  miso,
    output logic                  mosi,
    output spi_host_pkg::spi_rsp_t rx_word
);

    localparam int W = `SPI_DATA_WIDTH;

    logic [W-1:0] tx_q;
    logic [W-1:0] rx_q;

    assign mosi         = tx_q[W-1];    // Current outgoing bit
    assign rx_word.data = rx_q;

    // Transmit side feeding the data-out pin
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_q <= '0;
        end else if (load) begin
            tx_q <= load_data.data;
        end else if (launch) begin
            tx_q <= {tx_q[W-2:0], 1'b0};   // Next bit to MSB
        end
    end

    // Receive side
    always_ff @(posedge clk) begin
        if (sample) begin
            rx_q <= {rx_q[W-2:0], miso};
        end
    end

endmodule

// File: src/spi_host_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI host frame control
// Runs one chip select frame per command word and hands off the reply
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "spi_host_consts.svh"

module spi_host_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    // Command side
    input  logic                   word_valid,
    output logic                   word_ready,
    input  spi_host_pkg::spi_cmd_t word,
    // Shift register and clock generator
    output logic                   load,
    output spi_host_pkg::spi_cmd_t load_data,
    output logic                   sclk_enable,
    input  logic                   sample,
    output logic                   cs_n,
    input  spi_host_pkg::spi_rsp_t rx_word,
    // Response side
    output logic                   rsp_valid,
    input  logic                   rsp_ready,
    output spi_host_pkg::spi_rsp_t rsp
);

    localparam int W  = `SPI_DATA_WIDTH;
    localparam int CW = $clog2(W);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_XFER,
        ST_DONE
    } state_t;

    state_t        state;
    logic [CW-1:0] bit_cnt;             // Samples taken this frame
    logic          last_sample;

    assign word_ready = (state == ST_IDLE);
    assign load       = word_valid && word_ready;
    assign load_data  = word;

    assign last_sample = sample && (bit_cnt == CW'(W - 1));

    // Dropped on the final sample so sclk falls together with cs_n rising
    assign sclk_enable = (state == ST_XFER) && !last_sample;
    assign cs_n        = (state != ST_XFER);

    // Shifter is idle in done, so its word stays put until accepted
    assign rsp_valid = (state == ST_DONE);
    assign rsp       = rx_word;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= ST_IDLE;
            bit_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (load) begin
                        state   <= ST_XFER;   // Chip select low next cycle
                        bit_cnt <= '0;
                    end
                end
                ST_XFER: begin
                    if (sample) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (last_sample) begin
                            state <= ST_DONE;
                        end
                    end
                end
                ST_DONE: begin
                    // Back-pressure holds here with chip select high
                    if (rsp_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// File: src/spi_host_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI host subsystem top level
// Command queue, frame control, serial clock, shifter and response queue
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "spi_host_consts.svh"

module spi_host_top (
    input  logic                   clk,
    input  logic                   rst,
    // Host command stream
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    input  spi_host_pkg::spi_cmd_t cmd,
    // Host response stream
    output logic                   rsp_valid,
    input  logic                   rsp_ready,
    output spi_host_pkg::spi_rsp_t rsp,
    // Serial pins
    output logic                   spi_sclk,
    output logic                   spi_mosi,
    input  logic                   spi_miso,
    output logic                   spi_cs_n
);

    logic                   word_valid;
    logic                   word_ready;
    spi_host_pkg::spi_cmd_t word;
    logic                   load;
    spi_host_pkg::spi_cmd_t load_data;
    logic                   sclk_enable;
    logic                   launch;
    logic                   sample;
    spi_host_pkg::spi_rsp_t rx_word;
    logic                   ctrl_rsp_valid;
    logic                   ctrl_rsp_ready;
    spi_host_pkg::spi_rsp_t ctrl_rsp;

    spi_xfer_fifo #(
        .payload_t (spi_host_pkg::spi_cmd_t),
        .DEPTH     (`SPI_FIFO_DEPTH)
    ) u_cmd_fifo (
        .clk (clk),  .rst (rst),
        .in_valid  (cmd_valid),  .in_ready  (cmd_ready),  .in_data  (cmd),
        .out_valid (word_valid), .out_ready (word_ready), .out_data (word)
    );

    spi_host_ctrl u_ctrl (
        .clk (clk),  .rst (rst),
        .word_valid (word_valid), .word_ready (word_ready), .word (word),
        .load (load), .load_data (load_data), .sclk_enable (sclk_enable),
        .sample (sample), .cs_n (spi_cs_n), .rx_word (rx_word),
        .rsp_valid (ctrl_rsp_valid), .rsp_ready (ctrl_rsp_ready), .rsp (ctrl_rsp)
    );

    spi_sclk_gen u_sclk_gen (
        .clk (clk),  .rst (rst),
        .enable (sclk_enable), .sclk (spi_sclk), .launch (launch), .sample (sample)
    );

    spi_shift_reg u_shift_reg (
        .clk (clk),  .rst (rst),
        .load (load), .load_data (load_data), .launch (launch), .sample (sample),
        .miso (spi_miso), .mosi (spi_mosi), .rx_word (rx_word)
    );

    spi_xfer_fifo #(
        .payload_t (spi_host_pkg::spi_rsp_t),
        .DEPTH     (`SPI_FIFO_DEPTH)
    ) u_rsp_fifo (
        .clk (clk),  .rst (rst),
        .in_valid  (ctrl_rsp_valid), .in_ready  (ctrl_rsp_ready), .in_data  (ctrl_rsp),
        .out_valid (rsp_valid),      .out_ready (rsp_ready),      .out_data (rsp)
    );

endmodule

// File: verif/spi_host_chk.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI host protocol checker
// Reset levels, frame shape and response hold rules at the top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "spi_host_consts.svh"

module spi_host_chk (
    input logic                   clk,
    input logic                   rst,
    input logic                   cmd_ready,
    input logic                   rsp_valid,
    input logic                   rsp_ready,
    input spi_host_pkg::spi_rsp_t rsp,
    input logic                   spi_sclk,
    input logic                   spi_mosi,
    input logic                   spi_cs_n,
    input logic                   ctrl_rsp_valid,
    input logic                   ctrl_rsp_ready,
    input spi_host_pkg::spi_rsp_t ctrl_rsp
);

    localparam int W  = `SPI_DATA_WIDTH;
    localparam int CW = $clog2(W) + 1;

    logic [CW-1:0] rise_cnt;   // Rising sclk edges in the current frame
    logic          sclk_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rise_cnt <= '0;
            sclk_q   <= 1'b0;
        end else begin
            sclk_q <= spi_sclk;
            if (spi_cs_n) begin
                rise_cnt <= '0;
            end else if (spi_sclk && !sclk_q) begin
                rise_cnt <= rise_cnt + 1'b1;
            end
        end
    end

    reset_idle: assert property (@(posedge clk)
        $fell(rst) |-> (spi_cs_n && !spi_sclk && !spi_mosi && !rsp_valid && !cmd_ready))
        else $error("Serial pins or handshakes not idle when reset was released");

    // Count is complete on the cycle chip select goes back high
    frame_edges: assert property (@(posedge clk) disable iff (rst)
        $rose(spi_cs_n) |-> (rise_cnt == CW'(W)))
        else $error("Frame ended with %0d rising sclk edges", rise_cnt);

    sclk_idle: assert property (@(posedge clk) disable iff (rst)
        spi_cs_n |-> !spi_sclk)
        else $error("sclk high while chip select is released");

    rsp_hold: assert property (@(posedge clk) disable iff (rst)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)))
        else $error("Response dropped or changed before it was accepted");

    // Control parked in done with chip select high
    done_hold: assert property (@(posedge clk) disable iff (rst)
        (ctrl_rsp_valid && !ctrl_rsp_ready) |=> (ctrl_rsp_valid && $stable(ctrl_rsp) && spi_cs_n))
        else $error("Control lost its word or ran a frame under back-pressure");

endmodule

bind spi_host_top spi_host_chk u_chk (
    .clk            (clk),
    .rst            (rst),
    .cmd_ready      (cmd_ready),
    .rsp_valid      (rsp_valid),
    .rsp_ready      (rsp_ready),
    .rsp            (rsp),
    .spi_sclk       (spi_sclk),
    .spi_mosi       (spi_mosi),
    .spi_cs_n       (spi_cs_n),
    .ctrl_rsp_valid (ctrl_rsp_valid),
    .ctrl_rsp_ready (ctrl_rsp_ready),
    .ctrl_rsp       (ctrl_rsp)
);

// File: verif/spi_host_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI host testbench
// Command stimulus, SPI device model and in-order data checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "spi_host_consts.svh"

module spi_host_tb;

    localparam int W               = `SPI_DATA_WIDTH;
    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 8;
    localparam int SEED            = 92238;
    localparam int FRAME_CYCLES    = 2 * `SPI_CLK_DIV * W + 32;   // 160 with margin
    localparam int WATCHDOG_CYCLES = 40 * FRAME_CYCLES;
    localparam int HELD_FRAMES     = `SPI_FIFO_DEPTH + 1;
    localparam logic [1:0] MODE_OPEN = 2'd0;
    localparam logic [1:0] MODE_HOLD = 2'd1;
    localparam logic [1:0] MODE_RAND = 2'd2;

    logic                   clk;
    logic                   rst;
    logic                   cmd_valid;
    logic                   cmd_ready;
    spi_host_pkg::spi_cmd_t cmd;
    logic                   rsp_valid;
    logic                   rsp_ready;
    spi_host_pkg::spi_rsp_t rsp;
    logic                   spi_sclk;
    logic                   spi_mosi;
    logic                   spi_miso;
    logic                   spi_cs_n;

    logic [1:0]   rsp_mode;
    logic [1:0]   mode_now;
    logic [W-1:0] sent[$];      // Accepted command words
    logic [W-1:0] exp_rsp[$];   // Replies sent by the device
    logic [W-1:0] reply;
    logic [W-1:0] cap;
    logic [W-1:0] tx_exp;
    logic [W-1:0] rx_exp;
    logic         in_frame;
    logic         bp_phase;
    logic         full_seen;
    int           errors;
    int           sent_count;
    int           rsp_count;

    spi_host_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: not all responses arrived within %0d cycles", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    // Starts at 2 ns after an edge, ends 2 ns after the accepting edge
    task automatic send_cmd(input logic [W-1:0] w);
        cmd_valid = 1'b1;
        cmd.data  = w;
        do @(posedge clk); while (!cmd_ready);
        #2;
        cmd_valid = 1'b0;
    endtask

    task automatic wait_drained();
        while (rsp_count != sent_count) begin
            @(posedge clk);
            #2;
        end
    endtask

    always @(posedge clk) begin
        mode_now = rsp_mode;
        if (!rst && cmd_valid && cmd_ready) begin
            sent.push_back(cmd.data);
            sent_count++;
        end
        if (bp_phase && !cmd_ready) full_seen = 1'b1;
        if (!rst && rsp_valid && rsp_ready) begin
            if (exp_rsp.size() == 0) begin
                errors++;
                $display("Response accepted with no frame pending");
            end else begin
                rx_exp = exp_rsp.pop_front();
                assert (rsp.data == rx_exp) else begin
                    errors++;
                    $display("Mismatch rsp: got %h expected %h", rsp.data, rx_exp);
                end
                rsp_count++;
            end
        end
        #2;
        case (mode_now)
            MODE_OPEN: rsp_ready = 1'b1;
            MODE_HOLD: rsp_ready = 1'b0;
            default:   rsp_ready = ($urandom % 32'd2) != 32'd0;
        endcase
    end

    // SPI device model in mode 0
    always @(negedge spi_cs_n) begin
        if (!rst) begin
            reply = W'($urandom);
            exp_rsp.push_back(reply);
            in_frame = 1'b1;
            cap      = '0;
            #2 spi_miso = reply[W-1];
        end
    end

    always @(negedge spi_sclk) begin
        if (in_frame) begin
            reply = reply << 1;
            #2 spi_miso = reply[W-1];
        end
    end

    always @(posedge spi_sclk) begin
        if (in_frame) cap = {cap[W-2:0], spi_mosi};
    end

    always @(posedge spi_cs_n) begin
        if (in_frame) begin
            in_frame = 1'b0;
            if (sent.size() == 0) begin
                errors++;
                $display("Frame seen on the serial pins with no accepted command");
            end else begin
                tx_exp = sent.pop_front();
                assert (cap == tx_exp) else begin
                    errors++;
                    $display("Mismatch spi_mosi: got %h expected %h", cap, tx_exp);
                end
            end
        end
    end

    // Mode 0 data stays put while sclk is high
    mosi_stable: assert property (@(posedge clk) disable iff (rst)
        (spi_sclk && !spi_cs_n) |-> $stable(spi_mosi))
        else begin
            errors++;
            $display("spi_mosi changed while sclk was high");
        end

    initial begin
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        rsp_ready = 1'b0;
        spi_miso  = 1'b0;
        rsp_mode  = MODE_HOLD;
        in_frame  = 1'b0;
        bp_phase  = 1'b0;
        full_seen = 1'b0;
        errors    = 0;
        void'($urandom(SEED));
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rst = 1'b0;

        // Corner words with responses always taken
        rsp_mode = MODE_OPEN;
        send_cmd(16'hA5C3);
        send_cmd(16'h0001);
        send_cmd(16'h8000);
        send_cmd(16'hFFFF);
        wait_drained();

        // Back-pressure fills both queues and control
        rsp_mode = MODE_HOLD;
        bp_phase = 1'b1;
        repeat (6) send_cmd(W'($urandom));
        // Wait for the last frame that fits to end with its reply parked in control
        while (exp_rsp.size() < HELD_FRAMES || !spi_cs_n) begin
            @(posedge clk);
        end
        repeat (FRAME_CYCLES) @(posedge clk);   // Room for one more frame
        assert (full_seen) else begin
            errors++;
            $display("cmd_ready never fell while responses were held back");
        end
        assert (rsp_valid) else begin
            errors++;
            $display("Mismatch rsp_valid: got %h expected %h", rsp_valid, 1'b1);
        end
        assert (exp_rsp.size() == HELD_FRAMES) else begin
            errors++;
            $display("A frame ran while control was holding a response");
        end
        #2;
        bp_phase = 1'b0;
        rsp_mode = MODE_OPEN;
        wait_drained();

        rsp_mode = MODE_RAND;   // Burst with random host stalls
        repeat (20) send_cmd(W'($urandom));
        wait_drained();
        assert (sent.size() == 0 && exp_rsp.size() == 0) else begin
            errors++;
            $display("Words left over after the last response");
        end

        $display("Summary: %0d commands, %0d responses, %0d errors",
                 sent_count, rsp_count, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+src
src/spi_host_pkg.sv
src/spi_xfer_fifo.sv
src/spi_sclk_gen.sv
src/spi_shift_reg.sv
src/spi_host_ctrl.sv
src/spi_host_top.sv
verif/spi_host_chk.sv
verif/spi_host_tb.sv

// File: Makefile
# Verilator build and run for the SPI host testbench

VERILATOR ?= verilator
TOP       ?= spi_host_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
HEADERS   := $(wildcard src/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The run passes only if the pass line shows up in the simulator output
run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(BUILD_DIR)
